// File: Bender.yml
package:
  name: mem_back_end

sources:
  - design/memPipePkg.sv
  - design/cp0Pkg.sv
  - design/memAddrStage.sv
  - design/memStage.sv
  - design/wbStage.sv
  - design/dataRam.sv
  - design/cp0Regs.sv
  - design/memBackEnd.sv
  - target: simulation
    files:
      - verification/memBackEndChecker.sv
      - verification/tbMemBackEnd.sv

// File: design/cp0Pkg.sv
/*
 * Reduced CP0 package.
 * Register selectors, exception codes and Status/Cause field positions.
 */
package cp0Pkg;

    typedef enum logic [4:0] {
        BADVADDR = 5'd8,
        STATUS   = 5'd12,
        CAUSE    = 5'd13,
        EPC      = 5'd14
    } cp0SelE;

    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,    // address error on load
        EXC_ADES = 5'd5     // address error on store
    } excCodeE;

    // Status fields
    localparam int STATUS_IE    = 0;
    localparam int STATUS_EXL   = 1;
    localparam int STATUS_IM_LO = 8;
    localparam int STATUS_IM_HI = 15;
    localparam logic [31:0] STATUS_WMASK = 32'h0000_FF03;   // IM, EXL, IE

    // Cause fields
    localparam int CAUSE_IP_LO  = 8;
    localparam int CAUSE_IP_HI  = 15;
    localparam int CAUSE_EXC_LO = 2;
    localparam int CAUSE_EXC_HI = 6;

endpackage

// File: design/cp0Regs.sv
/*
 * Reduced CP0: Status, Cause, EPC and BadVAddr.
 * Forms the pending interrupt and records exception state.
 */
module cp0Regs import memPipePkg::*, cp0Pkg::*; (
    input  logic              clk,
    input  logic              rstN_i,
    input  logic [5:0]        intReq_i,
    input  cp0SelE            sel_i,
    input  logic              wen_i,
    input  logic [WORD_W-1:0] wdata_i,
    input  logic              excTake_i,
    input  excCodeE           excCode_i,
    input  logic [WORD_W-1:0] excPc_i,
    input  logic [WORD_W-1:0] excBadVAddr_i,
    output logic [WORD_W-1:0] rdata_o,
    output logic              intPending_o
);
    logic [WORD_W-1:0] statusReg;
    logic [5:0]        hwIp;        // Cause.IP7..2
    excCodeE           causeExc;
    logic [WORD_W-1:0] epcReg;
    logic [WORD_W-1:0] badVAddrReg;
    logic [WORD_W-1:0] causeWord;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            statusReg   <= '0;  // interrupts off
            hwIp        <= '0;
            causeExc    <= EXC_INT;
            epcReg      <= '0;
            badVAddrReg <= '0;
        end else begin
            hwIp <= intReq_i;   // sampled every cycle
            if (excTake_i) begin
                statusReg[STATUS_EXL] <= 1'b1;
                causeExc              <= excCode_i;
                epcReg                <= excPc_i;
                if (excCode_i != EXC_INT)
                    badVAddrReg <= excBadVAddr_i;
            end else if (wen_i) begin
                case (sel_i)
                    STATUS:  statusReg <= wdata_i & STATUS_WMASK;
                    EPC:     epcReg    <= wdata_i;
                    default: ;  // Cause and BadVAddr are read only
                endcase
            end
        end
    end

    always_comb begin
        causeWord = '0;
        causeWord[CAUSE_IP_HI:CAUSE_IP_LO]   = {hwIp, 2'b00};
        causeWord[CAUSE_EXC_HI:CAUSE_EXC_LO] = causeExc;
    end

    always_comb begin
        case (sel_i)
            STATUS:   rdata_o = statusReg;
            CAUSE:    rdata_o = causeWord;
            EPC:      rdata_o = epcReg;
            BADVADDR: rdata_o = badVAddrReg;
            default:  rdata_o = '0;
        endcase
    end

    assign intPending_o = |(causeWord[CAUSE_IP_HI:CAUSE_IP_LO] &
                            statusReg[STATUS_IM_HI:STATUS_IM_LO])
                          && statusReg[STATUS_IE] && !statusReg[STATUS_EXL];

endmodule

// File: design/dataRam.sv
/*
 * Data RAM, word organized, one-cycle read latency.
 * Byte-enabled writes, read data held until the next read.
 */
module dataRam import memPipePkg::*; #(
    parameter int RAM_WORDS = 256
) (
    input  logic              clk,
    input  logic              en_i,
    input  logic              we_i,
    input  logic [3:0]        byteEn_i,
    input  logic [WORD_W-1:0] addr_i,
    input  logic [WORD_W-1:0] wdata_i,
    output logic [WORD_W-1:0] rdata_o
);
    localparam int AW = $clog2(RAM_WORDS);

    logic [WORD_W-1:0] mem [RAM_WORDS] = '{default: '0};
    logic [AW-1:0]     wordAddr;

    assign wordAddr = addr_i[AW+1:2];   // byte address in, word index out

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (byteEn_i[b])
                        mem[wordAddr][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end else begin
                rdata_o <= mem[wordAddr];
            end
        end
    end

endmodule

// File: design/memAddrStage.sv
/*
 * Address stage: first pipeline register of the back end.
 * Holds one instruction and flags misaligned word loads and stores.
 */
module memAddrStage import memPipePkg::*, cp0Pkg::*; (
    input  logic                 clk,
    input  logic                 rstN_i,
    input  logic                 inValid_i,
    input  memOpE                inOp_i,
    input  logic [WORD_W-1:0]    inPc_i,
    input  logic [WORD_W-1:0]    inAddr_i,
    input  logic [WORD_W-1:0]    inStoreData_i,
    input  logic [REG_NUM_W-1:0] inRegNum_i,
    input  cp0SelE               inCp0Sel_i,
    input  logic                 flush_i,
    input  logic                 nextAllowin_i,
    output logic                 inAllowin_o,
    output logic                 valid_o,
    output memOpE                op_o,
    output logic [WORD_W-1:0]    pc_o,
    output logic [WORD_W-1:0]    addr_o,
    output logic [WORD_W-1:0]    storeData_o,
    output logic [REG_NUM_W-1:0] regNum_o,
    output cp0SelE               cp0Sel_o,
    output logic                 addrErr_o,
    output excCodeE              errCode_o
);
    logic hasData;

    // nothing enters while the exception flushes this stage
    assign inAllowin_o = !flush_i && (!hasData || nextAllowin_i);
    assign valid_o     = hasData;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            hasData <= 1'b0;
        end else if (flush_i) begin
            hasData <= 1'b0;
        end else if (inAllowin_o) begin
            hasData <= inValid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid_i && inAllowin_o) begin
            op_o        <= inOp_i;
            pc_o        <= inPc_i;
            addr_o      <= inAddr_i;
            storeData_o <= inStoreData_i;
            regNum_o    <= inRegNum_i;
            cp0Sel_o    <= inCp0Sel_i;
        end
    end

    // lb has no alignment rule
    assign addrErr_o = (op_o inside {OP_LW, OP_SW}) && (addr_o[1:0] != 2'b00);
    assign errCode_o = (op_o == OP_SW) ? EXC_ADES : EXC_ADEL;

endmodule

// File: design/memBackEnd.sv
/*
 * Memory back end top: address, memory and writeback stages
 * with the data RAM and the reduced CP0.
 */
module memBackEnd import memPipePkg::*, cp0Pkg::*; #(
    parameter int RAM_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 rstN_i,
    input  logic                 inValid_i,
    output logic                 inAllowin_o,
    input  memOpE                inOp_i,
    input  logic [WORD_W-1:0]    inPc_i,
    input  logic [WORD_W-1:0]    inAddr_i,
    input  logic [WORD_W-1:0]    inStoreData_i,
    input  logic [REG_NUM_W-1:0] inRegNum_i,
    input  cp0SelE               inCp0Sel_i,
    input  logic [5:0]           intReq_i,
    output logic                 wbValid_o,
    input  logic                 wbAllowin_i,
    output logic [REG_NUM_W-1:0] wbRegNum_o,
    output logic [WORD_W-1:0]    wbData_o,
    output logic                 excValid_o,
    output excCodeE              excCode_o,
    output logic [WORD_W-1:0]    excPc_o,
    output logic [WORD_W-1:0]    excBadVAddr_o
);
    ////////////////////////////////////////////////////////////////////////////
    // inter-stage wires
    ////////////////////////////////////////////////////////////////////////////
    logic                 aValid, aAddrErr;
    memOpE                aOp;
    logic [WORD_W-1:0]    aPc, aAddr, aStoreData;
    logic [REG_NUM_W-1:0] aRegNum;
    cp0SelE               aCp0Sel;
    excCodeE              aErrCode;

    logic                 mAllowin, mFlush, mValid;
    memOpE                mOp;
    logic [REG_NUM_W-1:0] mRegNum;
    logic [WORD_W-1:0]    mResult;
    logic [1:0]           mAddrLow;
    logic                 wAllowin;

    logic                 ramEn, ramWe;
    logic [3:0]           ramByteEn;
    logic [WORD_W-1:0]    ramAddr, ramWdata, ramRdata;

    cp0SelE               cp0Sel;
    logic                 cp0Wen, intPending;
    logic [WORD_W-1:0]    cp0Wdata, cp0Rdata;

    memAddrStage addrStage_i (
        .clk, .rstN_i, .inValid_i, .inOp_i, .inPc_i, .inAddr_i, .inStoreData_i,
        .inRegNum_i, .inCp0Sel_i, .flush_i(mFlush), .nextAllowin_i(mAllowin),
        .inAllowin_o, .valid_o(aValid), .op_o(aOp), .pc_o(aPc), .addr_o(aAddr),
        .storeData_o(aStoreData), .regNum_o(aRegNum), .cp0Sel_o(aCp0Sel),
        .addrErr_o(aAddrErr), .errCode_o(aErrCode)
    );

    memStage #(.RAM_WORDS(RAM_WORDS)) memStage_i (
        .clk, .rstN_i, .valid_i(aValid), .op_i(aOp), .pc_i(aPc), .addr_i(aAddr),
        .storeData_i(aStoreData), .regNum_i(aRegNum), .cp0Sel_i(aCp0Sel),
        .addrErr_i(aAddrErr), .errCode_i(aErrCode), .nextAllowin_i(wAllowin),
        .intPending_i(intPending), .cp0Rdata_i(cp0Rdata), .allowin_o(mAllowin),
        .flush_o(mFlush), .valid_o(mValid), .op_o(mOp), .regNum_o(mRegNum),
        .result_o(mResult), .addrLow_o(mAddrLow), .ramEn_o(ramEn), .ramWe_o(ramWe),
        .ramByteEn_o(ramByteEn), .ramAddr_o(ramAddr), .ramWdata_o(ramWdata),
        .cp0Sel_o(cp0Sel), .cp0Wen_o(cp0Wen), .cp0Wdata_o(cp0Wdata),
        .excTake_o(excValid_o), .excCode_o, .excPc_o, .excBadVAddr_o
    );

    wbStage wbStage_i (
        .clk, .rstN_i, .valid_i(mValid), .op_i(mOp), .regNum_i(mRegNum),
        .result_i(mResult), .addrLow_i(mAddrLow), .ramRdata_i(ramRdata),
        .wbAllowin_i, .allowin_o(wAllowin), .wbValid_o, .wbRegNum_o, .wbData_o
    );

    dataRam #(.RAM_WORDS(RAM_WORDS)) dataRam_i (
        .clk, .en_i(ramEn), .we_i(ramWe), .byteEn_i(ramByteEn), .addr_i(ramAddr),
        .wdata_i(ramWdata), .rdata_o(ramRdata)
    );

    cp0Regs cp0Regs_i (
        .clk, .rstN_i, .intReq_i, .sel_i(cp0Sel), .wen_i(cp0Wen), .wdata_i(cp0Wdata),
        .excTake_i(excValid_o), .excCode_i(excCode_o), .excPc_i(excPc_o),
        .excBadVAddr_i(excBadVAddr_o), .rdata_o(cp0Rdata), .intPending_o(intPending)
    );

endmodule

// File: design/memPipePkg.sv
/*
 * Memory back-end pipeline package.
 * Opcodes, data widths and byte-lane helpers shared by the stages.
 */
package memPipePkg;

    localparam int WORD_W    = 32;
    localparam int REG_NUM_W = 5;   // reg 0 means no writeback

    typedef enum logic [2:0] {
        OP_ALU,
        OP_LW,
        OP_LB,
        OP_SW,
        OP_MFC0,
        OP_MTC0
    } memOpE;

    function automatic logic isLoad(memOpE op);
        return op inside {OP_LW, OP_LB};
    endfunction

    function automatic logic writesReg(memOpE op);
        return op inside {OP_ALU, OP_LW, OP_LB, OP_MFC0};
    endfunction

    // only word stores exist, so all lanes or none
    function automatic logic [3:0] storeByteEn(memOpE op);
        return (op == OP_SW) ? 4'hF : 4'h0;
    endfunction

    function automatic logic [WORD_W-1:0] loadByte(logic [WORD_W-1:0] word, logic [1:0] lane);
        logic [7:0] b;
        b = word[8*lane +: 8];
        return {{(WORD_W-8){b[7]}}, b};
    endfunction

endpackage

// File: design/memStage.sv
/*
 * Memory stage: takes interrupts and address errors, flushes the
 * younger instruction, accesses CP0 and issues data RAM requests.
 */
module memStage import memPipePkg::*, cp0Pkg::*; #(
    parameter int RAM_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 rstN_i,
    input  logic                 valid_i,
    input  memOpE                op_i,
    input  logic [WORD_W-1:0]    pc_i,
    input  logic [WORD_W-1:0]    addr_i,
    input  logic [WORD_W-1:0]    storeData_i,
    input  logic [REG_NUM_W-1:0] regNum_i,
    input  cp0SelE               cp0Sel_i,
    input  logic                 addrErr_i,
    input  excCodeE              errCode_i,
    input  logic                 nextAllowin_i,
    input  logic                 intPending_i,
    input  logic [WORD_W-1:0]    cp0Rdata_i,
    output logic                 allowin_o,
    output logic                 flush_o,
    output logic                 valid_o,
    output memOpE                op_o,
    output logic [REG_NUM_W-1:0] regNum_o,
    output logic [WORD_W-1:0]    result_o,
    output logic [1:0]           addrLow_o,
    output logic                 ramEn_o,
    output logic                 ramWe_o,
    output logic [3:0]           ramByteEn_o,
    output logic [WORD_W-1:0]    ramAddr_o,
    output logic [WORD_W-1:0]    ramWdata_o,
    output cp0SelE               cp0Sel_o,
    output logic                 cp0Wen_o,
    output logic [WORD_W-1:0]    cp0Wdata_o,
    output logic                 excTake_o,
    output excCodeE              excCode_o,
    output logic [WORD_W-1:0]    excPc_o,
    output logic [WORD_W-1:0]    excBadVAddr_o
);
    logic              hasData;
    logic [WORD_W-1:0] pcQ;
    logic [WORD_W-1:0] addrQ;
    logic [WORD_W-1:0] storeDataQ;
    logic              addrErrQ;
    excCodeE           errCodeQ;
    logic              commit;

    ////////////////////////////////////////////////////////////////////////////
    // stage register
    ////////////////////////////////////////////////////////////////////////////
    assign allowin_o = !hasData || nextAllowin_i;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            hasData <= 1'b0;
        end else if (excTake_o) begin
            hasData <= 1'b0;    // dropped, and the younger one is flushed
        end else if (allowin_o) begin
            hasData <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i && allowin_o && !excTake_o) begin
            op_o       <= op_i;
            pcQ        <= pc_i;
            addrQ      <= addr_i;
            storeDataQ <= storeData_i;
            regNum_o   <= regNum_i;
            cp0Sel_o   <= cp0Sel_i;
            addrErrQ   <= addrErr_i;
            errCodeQ   <= errCode_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // exception resolution, interrupt wins over address error
    ////////////////////////////////////////////////////////////////////////////
    assign excTake_o     = hasData && (intPending_i || addrErrQ);
    assign excCode_o     = intPending_i ? EXC_INT : errCodeQ;
    assign excPc_o       = pcQ;
    assign excBadVAddr_o = addrQ;
    assign flush_o       = excTake_o;

    assign valid_o   = hasData && !excTake_o;
    assign commit    = valid_o && nextAllowin_i;   // leaves for wbStage this edge
    assign result_o  = (op_o == OP_MFC0) ? cp0Rdata_i : addrQ;
    assign addrLow_o = addrQ[1:0];

    // RAM and CP0 side effects only on the commit edge
    assign ramEn_o     = commit && (isLoad(op_o) || op_o == OP_SW);
    assign ramWe_o     = commit && (op_o == OP_SW);
    assign ramByteEn_o = storeByteEn(op_o);
    assign ramAddr_o   = addrQ;
    assign ramWdata_o  = storeDataQ;
    assign cp0Wen_o    = commit && (op_o == OP_MTC0);
    assign cp0Wdata_o  = addrQ;     // mtc0 value travels as the ALU result

    // younger instruction flushed along with the dropped one
    assert property (@(posedge clk) disable iff (!rstN_i) excTake_o |=> !valid_i);

    assert property (@(posedge clk) disable iff (!rstN_i)
        ramEn_o |-> (ramAddr_o[WORD_W-1:2] < RAM_WORDS));

endmodule

// File: design/wbStage.sv
/*
 * Writeback stage: holds the committed instruction, extracts load data
 * and presents the register write.
 */
module wbStage import memPipePkg::*; (
    input  logic                 clk,
    input  logic                 rstN_i,
    input  logic                 valid_i,
    input  memOpE                op_i,
    input  logic [REG_NUM_W-1:0] regNum_i,
    input  logic [WORD_W-1:0]    result_i,
    input  logic [1:0]           addrLow_i,
    input  logic [WORD_W-1:0]    ramRdata_i,
    input  logic                 wbAllowin_i,
    output logic                 allowin_o,
    output logic                 wbValid_o,
    output logic [REG_NUM_W-1:0] wbRegNum_o,
    output logic [WORD_W-1:0]    wbData_o
);
    logic              hasData;
    memOpE             opQ;
    logic [WORD_W-1:0] resultQ;
    logic [1:0]        addrLowQ;

    // stores, mtc0 and reg 0 leave without a writeback
    assign allowin_o = !hasData || wbAllowin_i || !wbValid_o;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            hasData <= 1'b0;
        end else if (allowin_o) begin
            hasData <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i && allowin_o) begin
            opQ        <= op_i;
            wbRegNum_o <= regNum_i;
            resultQ    <= result_i;
            addrLowQ   <= addrLow_i;
        end
    end

    assign wbValid_o = hasData && writesReg(opQ) && (wbRegNum_o != '0);

    always_comb begin
        case (opQ)
            OP_LW:   wbData_o = ramRdata_i;
            OP_LB:   wbData_o = loadByte(ramRdata_i, addrLowQ);
            default: wbData_o = resultQ;
        endcase
    end

    // relies on dataRam holding its read data through the stall
    assert property (@(posedge clk) disable iff (!rstN_i)
        (wbValid_o && !wbAllowin_i) |=> (wbValid_o && $stable(wbRegNum_o) && $stable(wbData_o)));

endmodule

// File: verification/memBackEndChecker.sv
/*
 * Checker for the memory back end.
 * Compares writebacks and exceptions with the model queues.
 */
module memBackEndChecker import memPipePkg::*, cp0Pkg::*; (
    input  logic                 clk,
    input  logic                 rstN_i,
    input  logic                 wbValid_i,
    input  logic                 wbAllowin_i,
    input  logic [REG_NUM_W-1:0] wbRegNum_i,
    input  logic [WORD_W-1:0]    wbData_i,
    input  logic                 excValid_i,
    input  excCodeE              excCode_i,
    input  logic [WORD_W-1:0]    excPc_i,
    input  logic [WORD_W-1:0]    excBadVAddr_i,
    output logic                 idle_o,
    output int                   errCount_o,
    output int                   checkCount_o
);
    logic [36:0] wbQ[$];    // {reg, data}
    logic [69:0] excQ[$];   // {checkBad, code, pc, badVAddr}
    logic        stalled = 1'b0;
    logic [36:0] held;
    logic [36:0] wbExp;
    logic [69:0] excExp;

    initial begin
        errCount_o   = 0;
        checkCount_o = 0;
        idle_o       = 1'b1;
    end

    task automatic pushWb(logic [4:0] rn, logic [31:0] data);
        wbQ.push_back({rn, data});
        idle_o = 1'b0;
    endtask

    task automatic pushExc(logic [4:0] code, logic [31:0] pc, logic [31:0] bad, logic chkBad);
        excQ.push_back({chkBad, code, pc, bad});
        idle_o = 1'b0;
    endtask

    task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
        checkCount_o++;
        if (got !== exp) begin
            errCount_o++;
            $display("Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // sampled mid-cycle, inputs settle well before the falling edge
    always @(negedge clk) begin
        if (rstN_i) begin
            if (stalled && (!wbValid_i || {wbRegNum_i, wbData_i} !== held)) begin
                errCount_o++;
                $display("Error: wbRegNum_o/wbData_o %h/%h -> %h/%h while stalled",
                         held[36:32], held[31:0], wbRegNum_i, wbData_i);
            end
            stalled = wbValid_i && !wbAllowin_i;
            held    = {wbRegNum_i, wbData_i};

            if (wbValid_i && wbAllowin_i) begin
                if (wbQ.size() == 0) begin
                    errCount_o++;
                    $display("unexpected writeback to register %0d at %0t", wbRegNum_i, $time);
                end else begin
                    wbExp = wbQ.pop_front();
                    compare("wbRegNum_o", 32'(wbRegNum_i), 32'(wbExp[36:32]));
                    compare("wbData_o", wbData_i, wbExp[31:0]);
                end
            end

            if (excValid_i) begin
                if (excQ.size() == 0) begin
                    errCount_o++;
                    $display("unexpected exception at pc %h at %0t", excPc_i, $time);
                end else begin
                    excExp = excQ.pop_front();
                    compare("excCode_o", 32'(excCode_i), 32'(excExp[68:64]));
                    compare("excPc_o", excPc_i, excExp[63:32]);
                    if (excExp[69])
                        compare("excBadVAddr_o", excBadVAddr_i, excExp[31:0]);
                end
            end
            idle_o = (wbQ.size() == 0) && (excQ.size() == 0);
        end
    end

endmodule

// File: verification/tbMemBackEnd.sv
/*
 * Testbench for the memory back end: random traffic with a model,
 * an interrupt phase and random writeback back-pressure.
 */
module tbMemBackEnd import memPipePkg::*, cp0Pkg::*; ();
    localparam int N_RANDOM = 300;
    localparam int N_INSTR  = 2 * N_RANDOM + 20;  // misaligned ops bring a flushed partner

    logic clk = 1'b0, rstN_i = 1'b0, inValid_i = 1'b0, wbAllowin_i = 1'b1;
    memOpE inOp_i = OP_ALU;
    logic [31:0] inPc_i = '0, inAddr_i = '0, inStoreData_i = '0;
    logic [4:0] inRegNum_i = '0;
    cp0SelE inCp0Sel_i = STATUS;
    logic [5:0] intReq_i = '0;
    logic wbValid_o, inAllowin_o, excValid_o, idle;
    logic [4:0] wbRegNum_o;
    logic [31:0] wbData_o, excPc_o, excBadVAddr_o;
    excCodeE excCode_o;
    int errCount, checkCount;

    // model state
    logic [31:0] ramM[16];
    logic [31:0] statusM = '0, epcM = '0, badM = '0, pc = 32'h0000_1000;
    logic [4:0]  excM = '0;
    logic [5:0]  intReqM = '0;
    logic [31:0] stimState = 32'h3129, stallState, r, a;
    logic        stallOff = 1'b0;
    cp0SelE      selTab[4] = '{BADVADDR, STATUS, CAUSE, EPC};

    memBackEnd #(.RAM_WORDS(256)) memBackEnd_i (.*);

    memBackEndChecker checker_i (
        .clk, .rstN_i, .wbValid_i(wbValid_o), .wbAllowin_i, .wbRegNum_i(wbRegNum_o),
        .wbData_i(wbData_o), .excValid_i(excValid_o), .excCode_i(excCode_o),
        .excPc_i(excPc_o), .excBadVAddr_i(excBadVAddr_o), .idle_o(idle),
        .errCount_o(errCount), .checkCount_o(checkCount)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] rnd();
        stimState = xorshift(stimState);
        return stimState;
    endfunction

    // about one stall cycle in four
    always @(posedge clk) begin
        #5;
        stallState  = xorshift(stallState);
        wbAllowin_i = stallOff || (stallState[1:0] != 2'b00);
    end

    task automatic takeException(logic [4:0] code, logic [31:0] bad);
        checker_i.pushExc(code, pc, bad, code != EXC_INT);
        epcM       = pc;
        statusM[1] = 1'b1;  // EXL
        excM       = code;
        if (code != EXC_INT) badM = bad;
    endtask

    task automatic applyModel(memOpE op, logic [31:0] ad, logic [31:0] sd, logic [4:0] rn,
                              cp0SelE sel);
        logic [31:0] v;
        v = '0;
        case (op)
            OP_ALU:  v = ad;
            OP_LW:   v = ramM[ad[5:2]];
            OP_LB:   v = 32'($signed(ramM[ad[5:2]][8*ad[1:0] +: 8]));
            OP_MFC0: case (sel)
                STATUS:   v = statusM;
                CAUSE:    v = (32'(intReqM) << 10) | (32'(excM) << 2);
                EPC:      v = epcM;
                default:  v = badM;
            endcase
            default: ;
        endcase
        if (op inside {OP_LW, OP_SW} && ad[1:0] != 2'b00)
            takeException(op == OP_SW ? EXC_ADES : EXC_ADEL, ad);
        else if (op == OP_SW)
            ramM[ad[5:2]] = sd;
        else if (op == OP_MTC0 && sel == STATUS)
            statusM = ad & 32'h0000_FF03;
        else if (op == OP_MTC0 && sel == EPC)
            epcM = ad;
        else if (op != OP_MTC0 && rn != 0)
            checker_i.pushWb(rn, v);
    endtask

    // mode 0 normal, 1 flushed, 2 hit by the interrupt
    task automatic issue(memOpE op, logic [31:0] ad, logic [31:0] sd, logic [4:0] rn,
                         cp0SelE sel, int mode);
        logic acc;
        acc           = 1'b0;
        inOp_i        = op;
        inPc_i        = pc;
        inAddr_i      = ad;
        inStoreData_i = sd;
        inRegNum_i    = rn;
        inCp0Sel_i    = sel;
        inValid_i     = 1'b1;
        while (!acc) begin
            @(negedge clk) acc = inAllowin_o;
            @(posedge clk) #5;
        end
        inValid_i = 1'b0;
        if (mode == 0) applyModel(op, ad, sd, rn, sel);
        else if (mode == 2) takeException(EXC_INT, '0);
        pc += 4;
    endtask

    task automatic drain();
        stallOff = 1'b1;
        repeat (6) @(posedge clk);
        #5 stallOff = 1'b0;
    endtask

    initial begin
        for (int i = 0; i < 16; i++) ramM[i] = '0;
        stallState = xorshift(32'h3129);
        repeat (4) @(posedge clk);
        #5 rstN_i = 1'b1;

        for (int i = 0; i < N_RANDOM; i++) begin
            r = rnd();
            a = (r >> 8) % 16 * 4;
            case (r % 8)
                0, 1: issue(OP_ALU, rnd(), '0, 5'(r >> 3), STATUS, 0);
                2: issue(OP_SW, a, rnd(), 5'(r >> 3), STATUS, 0);
                3: issue(OP_LW, a, '0, 5'(r >> 3), STATUS, 0);
                4: issue(OP_LB, a + 32'(r[13:12]), '0, 5'(r >> 3), STATUS, 0);
                5: issue(OP_MFC0, '0, '0, 5'(r >> 3), selTab[r[5:4]], 0);
                6: issue(OP_MTC0, rnd(), '0, 5'(r >> 3), EPC, 0);
                default: begin
                    issue(r[3] ? OP_SW : OP_LW, a + 1 + r[14:13] % 3, rnd(), 5'd9, STATUS, 0);
                    issue(r[4] ? OP_SW : OP_ALU, 32'h4, rnd(), 5'd1, STATUS, 1);
                end
            endcase
        end

        ///////////////////////////////////////////////////////////////////////////
        // interrupt phase, pipeline empty around each step
        ///////////////////////////////////////////////////////////////////////////
        drain();
        issue(OP_MTC0, 32'h0000_0401, '0, '0, STATUS, 0);   // IE and IM2
        drain();
        intReq_i = 6'b000001;
        intReqM  = 6'b000001;
        repeat (2) @(posedge clk);
        #5 issue(OP_ALU, 32'h1234_5678, '0, 5'd7, STATUS, 2);
        drain();
        issue(OP_MFC0, '0, '0, 5'd3, EPC, 0);
        issue(OP_MFC0, '0, '0, 5'd4, STATUS, 0);   // EXL holds off a second one
        issue(OP_MFC0, '0, '0, 5'd5, CAUSE, 0);
        issue(OP_ALU, 32'h0BAD_F00D, '0, 5'd6, STATUS, 0);
        drain();
        intReq_i = '0;
        intReqM  = '0;
        repeat (2) @(posedge clk);
        #5 issue(OP_MTC0, '0, '0, '0, STATUS, 0);

        stallOff = 1'b1;
        while (!idle) @(posedge clk);
        repeat (4) @(posedge clk);
        $display("checks %0d, errors %0d", checkCount, errCount);
        if (errCount == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    initial begin
        #(N_INSTR * 40 * 40 + 20000);
        $display("watchdog expired with expected transfers still missing");
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: vlog.f
design/memPipePkg.sv
design/cp0Pkg.sv
design/memAddrStage.sv
design/memStage.sv
design/wbStage.sv
design/dataRam.sv
design/cp0Regs.sv
design/memBackEnd.sv
verification/memBackEndChecker.sv
verification/tbMemBackEnd.sv
